/* files.f */
hdl/mc_types_pkg.sv
hdl/request_mapper.sv
hdl/global_array.sv
hdl/request_scheduler.sv
hdl/request_queue_top.sv
bench/request_queue_sva.sv
bench/tb_request_queue.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tb_request_queue \
		-Mdir obj_dir -o tb_request_queue
	./obj_dir/tb_request_queue | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_request_queue.sv */
`default_nettype none

module tb_request_queue import mc_types_pkg::*; ();

	localparam int READ_ENTRIES = 8;
	localparam int WRITE_ENTRIES = 8;
	localparam int WRITE_HIGH = 6;
	localparam int NUM_REQUESTS = 2000;
	localparam int BURST_LEN = 24;
	localparam int DRAIN_TIMEOUT = 100; // cycles
	localparam int PHASE_TIMEOUT = 10000;

	logic clk;
	logic rst;
	logic in_valid;
	req_kind_t in_kind;
	addr_t in_addr;
	data_t in_data;
	logic read_full;
	logic write_full;
	logic out_valid;
	req_kind_t out_kind;
	addr_t out_addr;
	data_t out_data;

	// expected requests per kind, in acceptance order
	addr_t read_fifo [$];
	addr_t write_addr_fifo [$];
	data_t write_data_fifo [$];
	int read_occ;
	int write_occ;
	int sent;
	int seen;

	request_queue_top #(
		.READ_ENTRIES (READ_ENTRIES),
		.WRITE_ENTRIES(WRITE_ENTRIES),
		.WRITE_HIGH   (WRITE_HIGH)
	) i_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_kind   (in_kind),
		.in_addr   (in_addr),
		.in_data   (in_data),
		.read_full (read_full),
		.write_full(write_full),
		.out_valid (out_valid),
		.out_kind  (out_kind),
		.out_addr  (out_addr),
		.out_data  (out_data)
	);

	always #10 clk = ~clk;

	task automatic stop_run();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on first failure");
	endtask

	task automatic abort_run(input string why);
		$display("%s at time %0t", why, $time);
		stop_run();
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	// outputs and full levels are stable at the falling edge
	task automatic next_cycle();
		@(negedge clk);
		if (out_valid) begin
			seen++;
			if (out_kind == kind_read) begin
				if (read_fifo.size() == 0) begin
					abort_run("read output appeared with no read pending");
				end
				check_value("read address", 64'(out_addr), 64'(read_fifo.pop_front()));
				check_value("read data", out_data, '0);
				read_occ--;
			end else begin
				if (write_addr_fifo.size() == 0) begin
					abort_run("write output appeared with no write pending");
				end
				check_value("write address", 64'(out_addr), 64'(write_addr_fifo.pop_front()));
				check_value("write data", out_data, write_data_fifo.pop_front());
				write_occ--;
			end
		end
		check_value("read_full", 64'(read_full), 64'(read_occ == READ_ENTRIES));
		check_value("write_full", 64'(write_full), 64'(write_occ == WRITE_ENTRIES));
	endtask

	task automatic drive_request(input req_kind_t kind, input addr_t addr, input data_t data);
		in_valid = 1'b1;
		in_kind = kind;
		in_addr = addr;
		in_data = data; // random for reads too
		sent++;
		if (kind == kind_read) begin
			read_fifo.push_back(addr);
			read_occ++;
		end else begin
			write_addr_fifo.push_back(addr);
			write_data_fifo.push_back(data);
			write_occ++;
		end
	endtask

	task automatic send_random(input req_kind_t kind);
		drive_request(kind, $urandom, {$urandom, $urandom});
	endtask

	function automatic logic has_room(input req_kind_t kind);
		if (kind == kind_read) begin
			return read_occ < READ_ENTRIES;
		end
		return write_occ < WRITE_ENTRIES;
	endfunction

	task automatic idle_cycles(input int count);
		repeat (count) begin
			next_cycle();
			in_valid = 1'b0;
		end
	endtask

	// single strobe into an empty buffer, output two cycles later
	task automatic check_latency(input req_kind_t kind);
		send_random(kind);
		next_cycle();
		in_valid = 1'b0;
		check_value("out_valid one cycle after strobe", 64'(out_valid), 64'(0));
		next_cycle();
		check_value("out_valid two cycles after strobe", 64'(out_valid), 64'(1));
		check_value("out_kind of single request", 64'(out_kind), 64'(kind));
	endtask

	task automatic send_burst(input req_kind_t kind, input int count);
		int done_cnt;
		int cycles;
		done_cnt = 0;
		cycles = 0;
		while (done_cnt < count) begin
			if (cycles == PHASE_TIMEOUT) begin
				abort_run("timeout while sending a burst");
			end
			next_cycle();
			cycles++;
			if (has_room(kind)) begin
				send_random(kind);
				done_cnt++;
			end else begin
				in_valid = 1'b0;
			end
		end
	endtask

	task automatic random_phase();
		int start;
		int cycles;
		req_kind_t kind;
		start = sent;
		cycles = 0;
		while (sent - start < NUM_REQUESTS) begin
			if (cycles == PHASE_TIMEOUT * 4) begin
				abort_run("timeout in the random phase");
			end
			next_cycle();
			cycles++;
			kind = ($urandom_range(1) == 0) ? kind_read : kind_write;
			if (!has_room(kind)) begin
				kind = (kind == kind_read) ? kind_write : kind_read; // try the other table
			end
			if ($urandom_range(3) != 0 && has_room(kind)) begin
				send_random(kind);
			end else begin
				in_valid = 1'b0;
			end
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (read_fifo.size() != 0 || write_addr_fifo.size() != 0) begin
			if (cycles == DRAIN_TIMEOUT) begin
				abort_run("timeout waiting for pending requests to drain");
			end
			next_cycle();
			in_valid = 1'b0;
			cycles++;
		end
	endtask

	initial begin
		void'($urandom(92));
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_kind = kind_read;
		in_addr = '0;
		in_data = '0;
		read_occ = 0;
		write_occ = 0;
		sent = 0;
		seen = 0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		check_value("out_valid after reset", 64'(out_valid), 64'(0));
		check_value("read_full after reset", 64'(read_full), 64'(0));
		check_value("write_full after reset", 64'(write_full), 64'(0));
		idle_cycles(8); // nothing may come out yet

		check_latency(kind_read);
		check_latency(kind_write);

		send_burst(kind_read, BURST_LEN);
		wait_drained();
		send_burst(kind_write, BURST_LEN);
		wait_drained();

		random_phase();
		wait_drained();
		idle_cycles(20); // catch stray outputs

		if (seen == sent) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			abort_run("number of outputs differs from number of requests");
		end
	end

endmodule

`default_nettype wire

/* bench/request_queue_sva.sv */
`default_nettype none

module request_queue_sva import mc_types_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic in_valid,
	input wire req_kind_t in_kind,
	input wire logic read_full,
	input wire logic write_full,
	input wire logic out_valid,
	input wire req_kind_t out_kind,
	input wire data_t out_data
);

	int pending; // strobes taken minus outputs seen

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 0;
		end else begin
			pending <= pending + (in_valid ? 1 : 0) - (out_valid ? 1 : 0);
		end
	end

	// one output cycle per request
	out_per_request: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> (pending > 0))
		else $error("output strobe with no request outstanding");

	read_not_full: assert property (@(posedge clk) disable iff (rst)
		(in_valid && in_kind == kind_read) |-> !read_full)
		else $error("read strobe while the read table is full");

	write_not_full: assert property (@(posedge clk) disable iff (rst)
		(in_valid && in_kind == kind_write) |-> !write_full)
		else $error("write strobe while the write table is full");

	read_data_zero: assert property (@(posedge clk) disable iff (rst)
		(out_valid && out_kind == kind_read) |-> (out_data == '0))
		else $error("read output carries nonzero data");

endmodule

bind request_queue_top request_queue_sva i_sva (
	.clk        (clk),
	.rst        (rst),
	.in_valid   (in_valid),
	.in_kind    (in_kind),
	.read_full  (read_full),
	.write_full (write_full),
	.out_valid  (out_valid),
	.out_kind   (out_kind),
	.out_data   (out_data)
);

`default_nettype wire

/* hdl/request_queue_top.sv */
`default_nettype none

module request_queue_top import mc_types_pkg::*; #(
	parameter int READ_ENTRIES = 8,
	parameter int WRITE_ENTRIES = 8,
	parameter int WRITE_HIGH = 6
) (
	input wire logic clk,
	input wire logic rst,

	input wire logic in_valid,
	input wire req_kind_t in_kind,
	input wire addr_t in_addr,
	input wire data_t in_data,

	output logic read_full,
	output logic write_full,

	output logic out_valid,
	output req_kind_t out_kind,
	output addr_t out_addr,
	output data_t out_data
);

	logic alloc_valid;
	req_kind_t alloc_kind;
	idx_t alloc_index;
	addr_t alloc_addr;
	data_t alloc_data;

	// issue doubles as the slot release
	logic issue_valid;
	req_kind_t issue_kind;
	idx_t issue_index;

	request_mapper #(
		.READ_ENTRIES (READ_ENTRIES),
		.WRITE_ENTRIES(WRITE_ENTRIES)
	) u_mapper (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_kind    (in_kind),
		.in_addr    (in_addr),
		.in_data    (in_data),
		.issue_valid(issue_valid),
		.issue_kind (issue_kind),
		.issue_index(issue_index),
		.read_full  (read_full),
		.write_full (write_full),
		.alloc_valid(alloc_valid),
		.alloc_kind (alloc_kind),
		.alloc_index(alloc_index),
		.alloc_addr (alloc_addr),
		.alloc_data (alloc_data)
	);

	global_array #(
		.READ_ENTRIES (READ_ENTRIES),
		.WRITE_ENTRIES(WRITE_ENTRIES)
	) u_array (
		.clk        (clk),
		.rst        (rst),
		.alloc_valid(alloc_valid),
		.alloc_kind (alloc_kind),
		.alloc_index(alloc_index),
		.alloc_addr (alloc_addr),
		.alloc_data (alloc_data),
		.issue_valid(issue_valid),
		.issue_kind (issue_kind),
		.issue_index(issue_index),
		.out_valid  (out_valid),
		.out_kind   (out_kind),
		.out_addr   (out_addr),
		.out_data   (out_data)
	);

	request_scheduler #(
		.READ_ENTRIES (READ_ENTRIES),
		.WRITE_ENTRIES(WRITE_ENTRIES),
		.WRITE_HIGH   (WRITE_HIGH)
	) u_scheduler (
		.clk        (clk),
		.rst        (rst),
		.alloc_valid(alloc_valid),
		.alloc_kind (alloc_kind),
		.alloc_index(alloc_index),
		.issue_valid(issue_valid),
		.issue_kind (issue_kind),
		.issue_index(issue_index)
	);

endmodule

`default_nettype wire

/* hdl/request_scheduler.sv */
`default_nettype none

module request_scheduler import mc_types_pkg::*; #(
	parameter int READ_ENTRIES = 8,
	parameter int WRITE_ENTRIES = 8,
	parameter int WRITE_HIGH = 6
) (
	input wire logic clk,
	input wire logic rst,

	input wire logic alloc_valid,
	input wire req_kind_t alloc_kind,
	input wire idx_t alloc_index,

	output logic issue_valid,
	output req_kind_t issue_kind,
	output idx_t issue_index
);

	typedef logic [IDX_W:0] cnt_t;

	cnt_t count [2]; // entry 0 reads, entry 1 writes
	idx_t head_idx [2];
	logic [1:0] push;
	logic [1:0] pop;
	logic pick_write;

	function automatic idx_t bump(input idx_t ptr, input int depth);
		if (ptr == idx_t'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// one age queue of slot indices per table
	for (genvar k = 0; k < 2; k++) begin : g_queue
		localparam int DEPTH = (k == 0) ? READ_ENTRIES : WRITE_ENTRIES;
		localparam req_kind_t KIND = (k == 0) ? kind_read : kind_write;

		idx_t mem [MAX_ENTRIES];
		idx_t rd_ptr;
		idx_t wr_ptr;
		cnt_t cnt;

		assign push[k] = alloc_valid && (alloc_kind == KIND);
		assign head_idx[k] = mem[rd_ptr];
		assign count[k] = cnt;

		always_ff @(posedge clk) begin
			if (push[k]) begin
				mem[wr_ptr] <= alloc_index;
			end
		end

		always_ff @(posedge clk) begin
			if (rst) begin
				rd_ptr <= '0;
				wr_ptr <= '0;
				cnt <= '0;
			end else begin
				if (push[k]) begin
					wr_ptr <= bump(wr_ptr, DEPTH);
				end
				if (pop[k]) begin
					rd_ptr <= bump(rd_ptr, DEPTH);
				end
				case ({push[k], pop[k]})
					2'b10: cnt <= cnt + 1'b1;
					2'b01: cnt <= cnt - 1'b1;
					default: cnt <= cnt; // both or neither
				endcase
			end
		end
	end

	// write drain at the high mark, else writes only when reads are idle
	assign pick_write = (count[1] != '0) &&
		((count[1] >= cnt_t'(WRITE_HIGH)) || (count[0] == '0));

	assign issue_valid = (count[0] != '0) || (count[1] != '0);
	assign issue_kind = pick_write ? kind_write : kind_read;
	assign issue_index = pick_write ? head_idx[1] : head_idx[0];

	assign pop[0] = issue_valid && !pick_write;
	assign pop[1] = issue_valid && pick_write;

endmodule

`default_nettype wire

/* hdl/global_array.sv */
`default_nettype none

module global_array import mc_types_pkg::*; #(
	parameter int READ_ENTRIES = 8,
	parameter int WRITE_ENTRIES = 8
) (
	input wire logic clk,
	input wire logic rst,

	input wire logic alloc_valid,
	input wire req_kind_t alloc_kind,
	input wire idx_t alloc_index,
	input wire addr_t alloc_addr,
	input wire data_t alloc_data,

	input wire logic issue_valid,
	input wire req_kind_t issue_kind,
	input wire idx_t issue_index,

	output logic out_valid,
	output req_kind_t out_kind,
	output addr_t out_addr,
	output data_t out_data
);

	addr_t read_addr_tab [READ_ENTRIES];
	addr_t write_addr_tab [WRITE_ENTRIES];
	data_t write_data_tab [WRITE_ENTRIES];

	addr_t sel_addr;
	data_t sel_data;

	// slot write from the mapper
	always_ff @(posedge clk) begin
		if (alloc_valid) begin
			for (int i = 0; i < READ_ENTRIES; i++) begin
				if (alloc_kind == kind_read && alloc_index == idx_t'(i)) begin
					read_addr_tab[i] <= alloc_addr;
				end
			end
			for (int i = 0; i < WRITE_ENTRIES; i++) begin
				if (alloc_kind == kind_write && alloc_index == idx_t'(i)) begin
					write_addr_tab[i] <= alloc_addr;
					write_data_tab[i] <= alloc_data;
				end
			end
		end
	end

	always_comb begin
		sel_addr = '0;
		sel_data = '0; // reads carry no data
		if (issue_kind == kind_read) begin
			for (int i = 0; i < READ_ENTRIES; i++) begin
				if (issue_index == idx_t'(i)) begin
					sel_addr = read_addr_tab[i];
				end
			end
		end else begin
			for (int i = 0; i < WRITE_ENTRIES; i++) begin
				if (issue_index == idx_t'(i)) begin
					sel_addr = write_addr_tab[i];
					sel_data = write_data_tab[i];
				end
			end
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		if (rst || !issue_valid) begin
			out_valid <= 1'b0;
			out_kind <= kind_read;
			out_addr <= '0;
			out_data <= '0;
		end else begin
			out_valid <= 1'b1;
			out_kind <= issue_kind;
			out_addr <= sel_addr;
			out_data <= sel_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/request_mapper.sv */
`default_nettype none

module request_mapper import mc_types_pkg::*; #(
	parameter int READ_ENTRIES = 8,
	parameter int WRITE_ENTRIES = 8
) (
	input wire logic clk,
	input wire logic rst,

	input wire logic in_valid,
	input wire req_kind_t in_kind,
	input wire addr_t in_addr,
	input wire data_t in_data,

	input wire logic issue_valid,
	input wire req_kind_t issue_kind,
	input wire idx_t issue_index,

	output logic read_full,
	output logic write_full,

	output logic alloc_valid,
	output req_kind_t alloc_kind,
	output idx_t alloc_index,
	output addr_t alloc_addr,
	output data_t alloc_data
);

	logic [READ_ENTRIES-1:0] read_free;
	logic [WRITE_ENTRIES-1:0] write_free;
	logic [READ_ENTRIES-1:0] read_free_nxt;
	logic [WRITE_ENTRIES-1:0] write_free_nxt;
	logic [MAX_ENTRIES-1:0] read_map;
	logic [MAX_ENTRIES-1:0] write_map;
	idx_t read_pick;
	idx_t write_pick;
	logic accept;

	// lowest set bit wins
	function automatic idx_t lowest_free(input logic [MAX_ENTRIES-1:0] map);
		idx_t pick;
		pick = '0;
		for (int i = MAX_ENTRIES - 1; i >= 0; i--) begin
			if (map[i]) begin
				pick = idx_t'(i);
			end
		end
		return pick;
	endfunction

	always_comb begin
		read_map = '0; // unused slots never free
		write_map = '0;
		read_map[READ_ENTRIES-1:0] = read_free;
		write_map[WRITE_ENTRIES-1:0] = write_free;
	end

	assign read_pick = lowest_free(read_map);
	assign write_pick = lowest_free(write_map);

	assign read_full = ~|read_free;
	assign write_full = ~|write_free;

	// strobe into a full table is dropped
	assign accept = in_valid && ((in_kind == kind_read) ? !read_full : !write_full);

	assign alloc_valid = accept;
	assign alloc_kind = in_kind;
	assign alloc_index = (in_kind == kind_read) ? read_pick : write_pick;
	assign alloc_addr = in_addr;
	assign alloc_data = (in_kind == kind_write) ? in_data : '0;

	// claim on accept, free on release
	always_comb begin
		read_free_nxt = read_free;
		write_free_nxt = write_free;
		for (int i = 0; i < READ_ENTRIES; i++) begin
			if (accept && in_kind == kind_read && read_pick == idx_t'(i)) begin
				read_free_nxt[i] = 1'b0;
			end
			if (issue_valid && issue_kind == kind_read && issue_index == idx_t'(i)) begin
				read_free_nxt[i] = 1'b1;
			end
		end
		for (int i = 0; i < WRITE_ENTRIES; i++) begin
			if (accept && in_kind == kind_write && write_pick == idx_t'(i)) begin
				write_free_nxt[i] = 1'b0;
			end
			if (issue_valid && issue_kind == kind_write && issue_index == idx_t'(i)) begin
				write_free_nxt[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			read_free <= '1;
			write_free <= '1;
		end else begin
			read_free <= read_free_nxt;
			write_free <= write_free_nxt;
		end
	end

endmodule

`default_nettype wire

/* hdl/mc_types_pkg.sv */
`default_nettype none

package mc_types_pkg;

	// request field widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;

	// slot index width, enough for 16 slots per table
	localparam int IDX_W = 4;
	localparam int MAX_ENTRIES = 2 ** IDX_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [IDX_W-1:0] idx_t;

	// request kind, also selects the table
	typedef enum logic {
		kind_read  = 1'b0,
		kind_write = 1'b1
	} req_kind_t;

endpackage

`default_nettype wire
